/* src/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Low bytes of the vectors in page FF
`define RESET_VECTOR_LO   8'hFC
`define IRQ_BRK_VECTOR_LO 8'hFE

`define STACK_PAGE        8'h01

// Power-up values of SP and the status byte, NV1BDIZC
`define SP_RESET          8'hFD
`define STATUS_RESET      8'h34

`endif

/* src/cpu_pkg.sv */
package cpu_pkg;

    // Fetch and decode present PC, everything else is execute
    typedef enum logic [1:0] {
        STATE_FETCH,
        STATE_DECODE,
        STATE_NEITHER
    } processor_state_t;

    typedef enum logic [3:0] {
        ADDRLO_FF, ADDRLO_FE, ADDRLO_FD, ADDRLO_FC,
        ADDRLO_PCLO, ADDRLO_RMEMBUFFER, ADDRLO_RMEM, ADDRLO_ALUOUT,
        ADDRLO_SP, ADDRLO_HOLD
    } addr_lo_src_t;

    typedef enum logic [2:0] {
        ADDRHI_1, ADDRHI_0, ADDRHI_FF, ADDRHI_PCHI,
        ADDRHI_RMEM, ADDRHI_ALUOUT, ADDRHI_HOLD
    } addr_hi_src_t;

    typedef enum logic [1:0] {
        READ_EN_R, READ_EN_W, READ_EN_NONE
    } read_en_t;

    typedef enum logic [2:0] {
        WMEMSRC_NONE, WMEMSRC_PCHI, WMEMSRC_PCLO,
        WMEMSRC_STATUS_BS, WMEMSRC_INSTR_STORE, WMEMSRC_RMEM
    } write_mem_src_t;

    // Register an instruction writes to memory
    typedef enum logic [1:0] {
        STORE_A, STORE_X, STORE_Y, STORE_STATUS
    } store_reg_t;

    typedef enum logic [1:0] {
        ALUDST_NONE, ALUDST_A, ALUDST_X, ALUDST_WMEM
    } alu_dst_t;

    typedef enum logic [1:0] {
        ALU_PASS, ALU_ADC, ALU_INC
    } alu_op_t;

    // Microcode step that commits the ALU result
    typedef enum logic [1:0] {
        INSTR_CTRL_NONE, INSTR_CTRL_1, INSTR_CTRL_2
    } instr_ctrl_t;

    typedef enum logic [7:0] {
        OP_BRK     = 8'h00,
        OP_PHP     = 8'h08,
        OP_PHA     = 8'h48,
        OP_JMP_ABS = 8'h4C,
        OP_ADC_IMM = 8'h69,
        OP_STA_ABS = 8'h8D,
        OP_LDA_IMM = 8'hA9,
        OP_LDA_ABS = 8'hAD,
        OP_INX     = 8'hE8
    } opcode_t;

endpackage : cpu_pkg

/* src/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic load_ir,
    input  logic [7:0] r_data,
    output cpu_pkg::opcode_t opcode,
    output cpu_pkg::store_reg_t store_reg,
    output cpu_pkg::alu_dst_t alu_out_dst,
    output cpu_pkg::alu_op_t alu_op
);
    import cpu_pkg::*;

    opcode_t ir;

    // In the decode cycle the opcode is still on the bus
    assign opcode = load_ir ? opcode_t'(r_data) : ir;

    always_ff @(posedge clk) begin
        if (rst) begin
            // 6502 NOP
            ir <= opcode_t'(8'hEA);
        end else if (rdy && load_ir) begin
            ir <= opcode_t'(r_data);
        end
    end

    always_comb begin
        store_reg   = STORE_A;
        alu_out_dst = ALUDST_NONE;
        alu_op      = ALU_PASS;
        case (opcode)
            OP_LDA_IMM, OP_LDA_ABS: begin
                alu_out_dst = ALUDST_A;
            end
            OP_ADC_IMM: begin
                alu_out_dst = ALUDST_A;
                alu_op      = ALU_ADC;
            end
            OP_INX: begin
                store_reg   = STORE_X;
                alu_out_dst = ALUDST_X;
                alu_op      = ALU_INC;
            end
            OP_PHP: begin
                store_reg = STORE_STATUS;
            end
            // STA and PHA store A, unknown opcodes do nothing
            default: begin
                store_reg = STORE_A;
            end
        endcase
    end

endmodule : instr_decode

/* src/ucode_sequencer.sv */
`timescale 1ns/1ps

module ucode_sequencer (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  cpu_pkg::opcode_t opcode,
    output cpu_pkg::processor_state_t state,
    output cpu_pkg::addr_lo_src_t ucode_addr_lo_src,
    output cpu_pkg::addr_hi_src_t ucode_addr_hi_src,
    output cpu_pkg::read_en_t ucode_r_en,
    output cpu_pkg::write_mem_src_t ucode_write_mem_src,
    output cpu_pkg::instr_ctrl_t ucode_instr_ctrl,
    output logic load_ir,
    output logic pc_inc,
    output logic pc_load_lo,
    output logic pc_load_hi,
    output logic sp_dec,
    output logic buf_load,
    output logic alu_commit,
    output logic set_i
);
    import cpu_pkg::*;

    logic [2:0] step;
    logic in_reset;
    // PC high byte arrives during the next fetch
    logic jump_pend;
    // ALU operand arrives during the next fetch
    logic commit_pend;
    logic last;
    logic jump_set;
    logic commit_set;
    logic push;

    assign load_ir = (state == STATE_DECODE);

    always_comb begin
        ucode_addr_lo_src   = ADDRLO_PCLO;
        ucode_addr_hi_src   = ADDRHI_PCHI;
        ucode_r_en          = READ_EN_R;
        ucode_write_mem_src = WMEMSRC_NONE;
        ucode_instr_ctrl    = INSTR_CTRL_NONE;
        {pc_inc, pc_load_lo, pc_load_hi, buf_load, alu_commit, set_i} = '0;
        {last, jump_set, commit_set, push} = '0;
        case (state)
            STATE_FETCH: begin
                pc_inc = 1'b1;
                if (jump_pend) begin
                    ucode_addr_hi_src = ADDRHI_RMEM;
                    pc_load_hi = 1'b1;
                end
                if (commit_pend) begin
                    ucode_instr_ctrl = INSTR_CTRL_1;
                    alu_commit = 1'b1;
                end
            end
            STATE_DECODE: begin
                case (opcode)
                    OP_LDA_IMM, OP_ADC_IMM: begin
                        pc_inc = 1'b1;
                        last = 1'b1;
                        commit_set = 1'b1;
                    end
                    OP_INX: begin
                        last = 1'b1;
                        commit_set = 1'b1;
                    end
                    OP_LDA_ABS, OP_STA_ABS, OP_JMP_ABS, OP_BRK: pc_inc = 1'b1;
                    // Dummy read of the next byte
                    OP_PHA, OP_PHP: pc_inc = 1'b0;
                    default: last = 1'b1;
                endcase
            end
            default: begin
                if (in_reset) begin
                    ucode_addr_hi_src = ADDRHI_FF;
                    if (step == 3'd0) begin
                        ucode_addr_lo_src = ADDRLO_FC;
                    end else begin
                        ucode_addr_lo_src = ADDRLO_FD;
                        pc_load_lo = 1'b1;
                        last = 1'b1;
                        jump_set = 1'b1;
                    end
                end else begin
                    case (opcode)
                        OP_LDA_ABS, OP_STA_ABS: begin
                            if (step == 3'd0) begin
                                pc_inc = 1'b1;
                                buf_load = 1'b1;
                            end else begin
                                ucode_addr_lo_src = ADDRLO_RMEMBUFFER;
                                ucode_addr_hi_src = ADDRHI_RMEM;
                                last = 1'b1;
                                if (opcode == OP_STA_ABS) begin
                                    ucode_r_en = READ_EN_W;
                                    ucode_write_mem_src = WMEMSRC_INSTR_STORE;
                                    ucode_instr_ctrl = INSTR_CTRL_2;
                                end else begin
                                    commit_set = 1'b1;
                                end
                            end
                        end
                        OP_PHA, OP_PHP: begin
                            push = 1'b1;
                            ucode_write_mem_src = WMEMSRC_INSTR_STORE;
                            last = 1'b1;
                        end
                        OP_JMP_ABS: begin
                            pc_load_lo = 1'b1;
                            last = 1'b1;
                            jump_set = 1'b1;
                        end
                        OP_BRK: begin
                            case (step)
                                3'd0: begin
                                    push = 1'b1;
                                    ucode_write_mem_src = WMEMSRC_PCHI;
                                end
                                3'd1: begin
                                    push = 1'b1;
                                    ucode_write_mem_src = WMEMSRC_PCLO;
                                end
                                3'd2: begin
                                    push = 1'b1;
                                    ucode_write_mem_src = WMEMSRC_STATUS_BS;
                                end
                                3'd3: begin
                                    ucode_addr_lo_src = ADDRLO_FE;
                                    ucode_addr_hi_src = ADDRHI_FF;
                                    set_i = 1'b1;
                                end
                                default: begin
                                    ucode_addr_lo_src = ADDRLO_FF;
                                    ucode_addr_hi_src = ADDRHI_FF;
                                    pc_load_lo = 1'b1;
                                    last = 1'b1;
                                    jump_set = 1'b1;
                                end
                            endcase
                        end
                        default: last = 1'b1;
                    endcase
                end
            end
        endcase
        // Stack push writes to page 1 and moves SP down
        if (push) begin
            ucode_addr_lo_src = ADDRLO_SP;
            ucode_addr_hi_src = ADDRHI_1;
            ucode_r_en = READ_EN_W;
        end
        sp_dec = push;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= STATE_NEITHER;
            step <= 3'd0;
            in_reset <= 1'b1;
            jump_pend <= 1'b0;
            commit_pend <= 1'b0;
        end else if (rdy) begin
            jump_pend <= jump_set;
            commit_pend <= commit_set;
            if (last) begin
                state <= STATE_FETCH;
                step <= 3'd0;
                in_reset <= 1'b0;
            end else if (state == STATE_FETCH) begin
                state <= STATE_DECODE;
            end else if (state == STATE_DECODE) begin
                state <= STATE_NEITHER;
            end else begin
                step <= step + 3'd1;
            end
        end
    end

endmodule : ucode_sequencer

/* src/mem_inputs.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module mem_inputs (
    input  cpu_pkg::processor_state_t state,
    input  cpu_pkg::addr_lo_src_t ucode_addr_lo_src,
    input  cpu_pkg::addr_hi_src_t ucode_addr_hi_src,
    input  cpu_pkg::read_en_t ucode_r_en,
    input  cpu_pkg::write_mem_src_t ucode_write_mem_src,
    input  cpu_pkg::instr_ctrl_t ucode_instr_ctrl,
    input  cpu_pkg::store_reg_t store_reg,
    input  cpu_pkg::alu_dst_t alu_out_dst,
    input  logic [7:0] a, x, y, sp, r_data, r_data_buffer, alu_out,
    input  logic [15:0] pc,
    input  logic n_flag, v_flag, d_flag, i_flag, z_flag, c_flag,
    output logic [15:0] addr_sel,
    output logic [7:0] w_data,
    output logic mem_r_en,
    output logic [1:0] addr_en
);
    import cpu_pkg::*;

    logic [7:0] status_b;

    // NV1BDIZC with B set, as pushed by BRK and PHP
    assign status_b = {n_flag, v_flag, 1'b1, 1'b1, d_flag, i_flag, z_flag, c_flag};

    always_comb begin
        addr_sel = 16'h0000;
        mem_r_en = 1'b1;
        addr_en = 2'b11;
        if (state == STATE_NEITHER) begin
            case (ucode_addr_lo_src)
                ADDRLO_FF:         addr_sel[7:0] = 8'hFF;
                ADDRLO_FE:         addr_sel[7:0] = 8'hFE;
                ADDRLO_FD:         addr_sel[7:0] = 8'hFD;
                ADDRLO_FC:         addr_sel[7:0] = 8'hFC;
                ADDRLO_PCLO:       addr_sel[7:0] = pc[7:0];
                ADDRLO_RMEMBUFFER: addr_sel[7:0] = r_data_buffer;
                ADDRLO_RMEM:       addr_sel[7:0] = r_data;
                ADDRLO_ALUOUT:     addr_sel[7:0] = alu_out;
                ADDRLO_SP:         addr_sel[7:0] = sp;
                default:           addr_en[0] = 1'b0;
            endcase
            case (ucode_addr_hi_src)
                ADDRHI_1:      addr_sel[15:8] = `STACK_PAGE;
                ADDRHI_0:      addr_sel[15:8] = 8'h00;
                ADDRHI_FF:     addr_sel[15:8] = 8'hFF;
                ADDRHI_PCHI:   addr_sel[15:8] = pc[15:8];
                ADDRHI_RMEM:   addr_sel[15:8] = r_data;
                ADDRHI_ALUOUT: addr_sel[15:8] = alu_out;
                default:       addr_en[1] = 1'b0;
            endcase
            if (ucode_r_en == READ_EN_W) begin
                mem_r_en = 1'b0;
            end
        end else begin
            // Fetch and decode always read at PC, high byte may come from the bus
            addr_sel[7:0] = pc[7:0];
            addr_sel[15:8] = (ucode_addr_hi_src == ADDRHI_RMEM) ? r_data : pc[15:8];
        end
    end

    always_comb begin
        w_data = 8'h00;
        if (ucode_instr_ctrl == INSTR_CTRL_2 && alu_out_dst == ALUDST_WMEM) begin
            w_data = alu_out;
        end
        case (ucode_write_mem_src)
            WMEMSRC_PCHI:      w_data = pc[15:8];
            WMEMSRC_PCLO:      w_data = pc[7:0];
            WMEMSRC_STATUS_BS: w_data = status_b;
            WMEMSRC_INSTR_STORE: begin
                case (store_reg)
                    STORE_A: w_data = a;
                    STORE_X: w_data = x;
                    STORE_Y: w_data = y;
                    default: w_data = status_b;
                endcase
            end
            WMEMSRC_RMEM:      w_data = r_data;
            default:           w_data = w_data;
        endcase
    end

endmodule : mem_inputs

/* src/cpu_regs.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module cpu_regs (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic pc_inc, pc_load_lo, pc_load_hi, sp_dec, buf_load, alu_commit, set_i,
    input  cpu_pkg::alu_op_t alu_op,
    input  cpu_pkg::alu_dst_t alu_out_dst,
    input  logic [7:0] r_data,
    input  logic [15:0] addr_sel,
    input  logic [1:0] addr_en,
    output logic [7:0] a, x, y, sp, r_data_buffer, alu_out,
    output logic [15:0] pc,
    output logic [15:0] addr,
    output logic n_flag, v_flag, d_flag, i_flag, z_flag, c_flag
);
    import cpu_pkg::*;

    localparam logic [7:0] STATUS_INIT = `STATUS_RESET;

    logic alu_carry;
    logic alu_ovf;
    logic reg_dst;
    logic [15:0] pc_base;
    logic [15:0] addr_q;

    always_comb begin
        alu_carry = c_flag;
        alu_ovf = v_flag;
        case (alu_op)
            ALU_ADC: begin
                {alu_carry, alu_out} = {1'b0, a} + {1'b0, r_data} + {8'h00, c_flag};
                // Signed overflow when both operands agree and the sum differs
                alu_ovf = (a[7] == r_data[7]) && (alu_out[7] != a[7]);
            end
            ALU_INC: alu_out = x + 8'd1;
            default: alu_out = r_data;
        endcase
    end

    assign reg_dst = alu_commit && (alu_out_dst == ALUDST_A || alu_out_dst == ALUDST_X);

    // Byte loads land first, then the increment
    assign pc_base = {pc_load_hi ? r_data : pc[15:8], pc_load_lo ? r_data : pc[7:0]};

    assign addr[15:8] = addr_en[1] ? addr_sel[15:8] : addr_q[15:8];
    assign addr[7:0] = addr_en[0] ? addr_sel[7:0] : addr_q[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            sp <= `SP_RESET;
            pc <= 16'h0000;
            {n_flag, v_flag} <= STATUS_INIT[7:6];
            {d_flag, i_flag, z_flag, c_flag} <= STATUS_INIT[3:0];
        end else if (rdy) begin
            pc <= pc_base + {15'h0000, pc_inc};
            if (sp_dec) begin
                sp <= sp - 8'd1;
            end
            if (set_i) begin
                i_flag <= 1'b1;
            end
            if (reg_dst) begin
                if (alu_out_dst == ALUDST_A) begin
                    a <= alu_out;
                end else begin
                    x <= alu_out;
                end
                n_flag <= alu_out[7];
                z_flag <= (alu_out == 8'h00);
                if (alu_op == ALU_ADC) begin
                    c_flag <= alu_carry;
                    v_flag <= alu_ovf;
                end
            end
        end
    end

    // Last bus address for the HOLD sources, and the operand byte buffer
    always_ff @(posedge clk) begin
        if (rdy) begin
            addr_q <= addr;
            if (buf_load) begin
                r_data_buffer <= r_data;
            end
        end
    end

endmodule : cpu_regs

/* src/cpu_core.sv */
`timescale 1ns/1ps

module cpu_core (
    input  logic clk,
    input  logic rst,
    input  logic rdy,
    input  logic [7:0] r_data,
    output logic [15:0] addr,
    output logic [7:0] w_data,
    output logic mem_r_en
);
    import cpu_pkg::*;

    processor_state_t state;
    addr_lo_src_t ucode_addr_lo_src;
    addr_hi_src_t ucode_addr_hi_src;
    read_en_t ucode_r_en;
    write_mem_src_t ucode_write_mem_src;
    instr_ctrl_t ucode_instr_ctrl;
    opcode_t opcode;
    store_reg_t store_reg;
    alu_dst_t alu_out_dst;
    alu_op_t alu_op;

    logic load_ir, pc_inc, pc_load_lo, pc_load_hi, sp_dec, buf_load, alu_commit, set_i;
    logic [7:0] a, x, y, sp, r_data_buffer, alu_out;
    logic [15:0] pc;
    logic [15:0] addr_sel;
    logic [1:0] addr_en;
    logic n_flag, v_flag, d_flag, i_flag, z_flag, c_flag;

    instr_decode u_decode (.*);

    ucode_sequencer u_sequencer (.*);

    // Bus address and write data selection
    mem_inputs u_mem_inputs (.*);

    cpu_regs u_regs (.*);

endmodule : cpu_core

/* testbench/cpu_core_asserts.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module cpu_core_asserts (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic [15:0] addr,
    input logic [7:0] w_data,
    input logic mem_r_en,
    input cpu_pkg::addr_hi_src_t hi_src
);
    import cpu_pkg::*;

    // A stalled write keeps its byte until rdy returns
    stalled_write_held: assert property (@(posedge clk) disable iff (rst)
        (!rdy && !mem_r_en) |=> $stable(w_data))
        else $error("write data moved while rdy was low");

    // Bus outputs frozen across a stall
    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> ($stable(addr) && $stable(mem_r_en)))
        else $error("addr or mem_r_en moved while rdy was low");

    read_in_reset: assert property (@(posedge clk) rst |-> mem_r_en)
        else $error("mem_r_en low during rst");

    read_after_reset: assert property (@(posedge clk) $fell(rst) |-> mem_r_en)
        else $error("mem_r_en low in the first cycle after rst");

    // Page 1 is written by pushes or by an absolute store
    stack_page_write: assert property (@(posedge clk) disable iff (rst)
        (!mem_r_en && addr[15:8] == `STACK_PAGE) |-> (hi_src == ADDRHI_1 || hi_src == ADDRHI_RMEM))
        else $error("page 1 write from an unexpected address source");

endmodule : cpu_core_asserts

bind cpu_core cpu_core_asserts u_asserts (
    .clk(clk),
    .rst(rst),
    .rdy(rdy),
    .addr(addr),
    .w_data(w_data),
    .mem_r_en(mem_r_en),
    .hi_src(ucode_addr_hi_src)
);

/* testbench/cpu_core_tb.sv */
`timescale 1ns/1ps

`include "cpu_config.svh"

module cpu_core_tb;
    import cpu_pkg::*;

    // About twice the cycles all tests need together
    localparam int CYCLE_LIMIT = 2000;

    logic clk;
    logic rst;
    logic rdy;
    logic [7:0] r_data = 8'h00;
    logic [15:0] addr;
    logic [7:0] w_data;
    logic mem_r_en;

    logic [7:0] mem [0:65535];
    logic [7:0] wmem [logic [15:0]];

    logic [15:0] fetch_addr_q[$];
    int fetch_cyc_q[$];
    opcode_t op_q[$];
    logic [15:0] rd_addr_q[$];
    logic [15:0] wr_addr_q[$];
    logic [7:0] wr_data_q[$];
    logic [15:0] ref_addr_q[$];
    logic [7:0] ref_data_q[$];
    int bus_cycles;
    int cycle_count = 0;
    logic [15:0] lfsr_state = 16'd41764;

    cpu_core uut (
        .clk(clk),
        .rst(rst),
        .rdy(rdy),
        .r_data(r_data),
        .addr(addr),
        .w_data(w_data),
        .mem_r_en(mem_r_en)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[15:8] ^ {a[6:0], a[7]} ^ 8'hC3;
    endfunction

    function automatic logic [7:0] read_mem(input logic [15:0] a);
        if (wmem.exists(a)) begin
            return wmem[a];
        end
        return mem[a];
    endfunction

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
    endfunction

    // Memory with one cycle of read latency, core writes kept apart
    always @(posedge clk) begin
        logic [7:0] rd;
        if (rst) begin
            wmem.delete();
            r_data <= read_mem(addr);
        end else if (rdy) begin
            rd = read_mem(addr);
            if (!mem_r_en) begin
                wmem[addr] = w_data;
            end
            r_data <= rd;
        end
    end

    // Bus log, only rdy-high cycles count
    always @(posedge clk) begin
        if (rst) begin
            bus_cycles = 0;
            fetch_addr_q.delete();
            fetch_cyc_q.delete();
            op_q.delete();
            rd_addr_q.delete();
            wr_addr_q.delete();
            wr_data_q.delete();
        end else if (rdy) begin
            bus_cycles = bus_cycles + 1;
            if (uut.u_sequencer.state == STATE_FETCH) begin
                fetch_addr_q.push_back(addr);
                fetch_cyc_q.push_back(bus_cycles);
            end
            if (uut.u_sequencer.state == STATE_DECODE) begin
                op_q.push_back(opcode_t'(r_data));
            end
            if (mem_r_en) begin
                rd_addr_q.push_back(addr);
            end else begin
                wr_addr_q.push_back(addr);
                wr_data_q.push_back(w_data);
            end
        end
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk) begin
        if (cycle_count >= CYCLE_LIMIT) begin
            fail_run("Timeout: the run went past its cycle limit");
        end else begin
            cycle_count <= cycle_count + 1;
        end
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %02h, expected %02h", $time, name, got, exp);
            fail_run("Byte value mismatch");
        end
    endtask

    task automatic check_addr(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %04h, expected %04h", $time, name, got, exp);
            fail_run("Address mismatch");
        end
    endtask

    task automatic check_opcode(input string name, input opcode_t got, input opcode_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %02h, expected %02h", $time, name, got, exp);
            fail_run("Opcode mismatch");
        end
    endtask

    task automatic require_count(input string what, input int got, input int min);
        if (got < min) begin
            $display("Too few %s logged: %0d, needed %0d", what, got, min);
            fail_run("Bus log is shorter than expected");
        end
    endtask

    task automatic hold_reset();
        @(negedge clk);
        rst = 1'b1;
        rdy = 1'b1;
    endtask

    // Memory fill, then the reset vector
    task automatic load_image(input logic [15:0] start);
        for (int i = 0; i < 65536; i++) begin
            mem[i] = fill_byte(16'(i));
        end
        mem[{8'hFF, `RESET_VECTOR_LO}] = start[7:0];
        mem[{8'hFF, 8'(`RESET_VECTOR_LO + 8'd1)}] = start[15:8];
    endtask

    task automatic put_instr(input logic [15:0] at, input int n, input logic [7:0] b0,
                             input logic [7:0] b1, input logic [7:0] b2);
        mem[at] = b0;
        if (n > 1) begin
            mem[16'(at + 16'd1)] = b1;
        end
        if (n > 2) begin
            mem[16'(at + 16'd2)] = b2;
        end
    endtask

    task automatic release_reset();
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic run_until_fetch(input logic [15:0] target, input int min_fetches,
                                   input bit stall);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (fetch_addr_q.size() >= min_fetches && fetch_addr_q[$] == target) begin
                done = 1'b1;
            end else if (stall) begin
                rdy = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end else begin
                rdy = 1'b1;
            end
        end
        rdy = 1'b1;
    endtask

    task automatic check_cycles(input int idx, input int exp);
        check_byte($sformatf("cycles of instruction %0d", idx),
                   8'(fetch_cyc_q[idx + 1] - fetch_cyc_q[idx]), 8'(exp));
    endtask

    task automatic test_reset_vector();
        hold_reset();
        load_image(16'h8000);
        put_instr(16'h8000, 3, OP_JMP_ABS, 8'h00, 8'h80);
        release_reset();
        run_until_fetch(16'h8000, 2, 1'b0);
        check_addr("first read", rd_addr_q[0], {8'hFF, `RESET_VECTOR_LO});
        check_addr("second read", rd_addr_q[1], {8'hFF, 8'(`RESET_VECTOR_LO + 8'd1)});
        check_addr("first fetch", fetch_addr_q[0], 16'h8000);
        check_opcode("first opcode", op_q[0], OP_JMP_ABS);
    endtask

    task automatic test_load_store(input bit stall);
        logic [7:0] imm;
        imm = 8'h5C;
        hold_reset();
        load_image(16'h0400);
        put_instr(16'h0400, 2, OP_LDA_IMM, imm, 8'h00);
        put_instr(16'h0402, 3, OP_STA_ABS, 8'h10, 8'h03);
        put_instr(16'h0405, 3, OP_LDA_ABS, 8'h10, 8'h03);
        put_instr(16'h0408, 3, OP_STA_ABS, 8'h20, 8'h03);
        put_instr(16'h040B, 3, OP_JMP_ABS, 8'h0B, 8'h04);
        release_reset();
        run_until_fetch(16'h040B, 5, stall);
        check_byte("mem[0310]", read_mem(16'h0310), imm);
        check_byte("mem[0320]", read_mem(16'h0320), imm);
        if (!stall) begin
            check_cycles(0, 2);
            check_cycles(1, 4);
            check_cycles(2, 4);
            check_cycles(3, 4);
            check_opcode("opcode 1", op_q[1], OP_STA_ABS);
            check_opcode("opcode 2", op_q[2], OP_LDA_ABS);
            ref_addr_q = wr_addr_q;
            ref_data_q = wr_data_q;
        end else begin
            require_count("writes", wr_addr_q.size(), ref_addr_q.size());
            for (int i = 0; i < ref_addr_q.size(); i++) begin
                check_addr($sformatf("write %0d addr", i), wr_addr_q[i], ref_addr_q[i]);
                check_byte($sformatf("write %0d data", i), wr_data_q[i], ref_data_q[i]);
            end
        end
    endtask

    task automatic test_alu();
        logic [7:0] status;
        logic [8:0] sum;
        // Carry in is C of the reset status
        status = `STATUS_RESET;
        sum = {1'b0, 8'h7F} + {1'b0, 8'h05} + {8'h00, status[0]};
        hold_reset();
        load_image(16'h0600);
        put_instr(16'h0600, 2, OP_LDA_IMM, 8'h7F, 8'h00);
        put_instr(16'h0602, 2, OP_ADC_IMM, 8'h05, 8'h00);
        put_instr(16'h0604, 1, OP_INX, 8'h00, 8'h00);
        put_instr(16'h0605, 3, OP_STA_ABS, 8'h30, 8'h03);
        put_instr(16'h0608, 3, OP_JMP_ABS, 8'h08, 8'h06);
        release_reset();
        run_until_fetch(16'h0608, 5, 1'b0);
        check_byte("mem[0330]", read_mem(16'h0330), sum[7:0]);
        check_cycles(1, 2);
        check_cycles(2, 2);
        check_cycles(3, 4);
    endtask

    task automatic test_stack_push();
        logic [7:0] status;
        logic [7:0] imm;
        imm = 8'h80;
        // N and Z follow the loaded byte, bits 5 and 4 read as one when pushed
        status = `STATUS_RESET;
        status[7] = imm[7];
        status[1] = (imm == 8'h00);
        status[5:4] = 2'b11;
        hold_reset();
        load_image(16'h0700);
        put_instr(16'h0700, 2, OP_LDA_IMM, imm, 8'h00);
        put_instr(16'h0702, 1, OP_PHA, 8'h00, 8'h00);
        put_instr(16'h0703, 1, OP_PHP, 8'h00, 8'h00);
        put_instr(16'h0704, 3, OP_JMP_ABS, 8'h04, 8'h07);
        release_reset();
        run_until_fetch(16'h0704, 4, 1'b0);
        require_count("writes", wr_addr_q.size(), 2);
        check_addr("PHA addr", wr_addr_q[0], {`STACK_PAGE, `SP_RESET});
        check_byte("PHA data", wr_data_q[0], imm);
        check_addr("PHP addr", wr_addr_q[1], {`STACK_PAGE, 8'(`SP_RESET - 8'd1)});
        check_byte("PHP data", wr_data_q[1], status);
        check_cycles(1, 3);
        check_cycles(2, 3);
    endtask

    task automatic test_brk_jmp();
        logic [7:0] status;
        status = `STATUS_RESET | 8'h30;
        hold_reset();
        load_image(16'h0900);
        put_instr(16'h0900, 2, OP_BRK, 8'hEA, 8'h00);
        mem[{8'hFF, `IRQ_BRK_VECTOR_LO}] = 8'h00;
        mem[{8'hFF, 8'(`IRQ_BRK_VECTOR_LO + 8'd1)}] = 8'h0A;
        put_instr(16'h0A00, 3, OP_JMP_ABS, 8'h40, 8'h0A);
        put_instr(16'h0A40, 3, OP_JMP_ABS, 8'h40, 8'h0A);
        release_reset();
        run_until_fetch(16'h0A40, 3, 1'b0);
        require_count("writes", wr_addr_q.size(), 3);
        for (int i = 0; i < 3; i++) begin
            check_addr($sformatf("BRK push %0d addr", i), wr_addr_q[i],
                       {`STACK_PAGE, 8'(`SP_RESET - 8'(i))});
        end
        check_byte("pushed PC high", wr_data_q[0], 8'h09);
        check_byte("pushed PC low", wr_data_q[1], 8'h02);
        check_byte("pushed status", wr_data_q[2], status);
        check_addr("fetch after BRK", fetch_addr_q[1], 16'h0A00);
        check_addr("fetch after JMP", fetch_addr_q[2], 16'h0A40);
        check_cycles(0, 7);
        check_cycles(1, 3);
    endtask

    initial begin
        rst = 1'b1;
        rdy = 1'b1;
        test_reset_vector();
        test_load_store(1'b0);
        test_alu();
        test_stack_push();
        test_brk_jmp();
        test_load_store(1'b1);
        $display("PASS: all tests");
        $finish;
    end

endmodule : cpu_core_tb

/* project.f */
+incdir+src
src/cpu_pkg.sv
src/instr_decode.sv
src/ucode_sequencer.sv
src/mem_inputs.sv
src/cpu_regs.sv
src/cpu_core.sv
testbench/cpu_core_asserts.sv
testbench/cpu_core_tb.sv

/* Makefile */
RTL = src/cpu_pkg.sv src/instr_decode.sv src/ucode_sequencer.sv \
      src/mem_inputs.sv src/cpu_regs.sv src/cpu_core.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+src $(RTL) --top-module cpu_core

sim:
	verilator --binary --timing --assert -f project.f --top-module cpu_core_tb
	./obj_dir/Vcpu_core_tb

clean:
	rm -rf obj_dir
